//--- bpu_consts.svh
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// datapath widths
`define BPU_XLEN          32
`define BPU_HIST_W        16

// direction predictor tables
`define BPU_BIM_ENTRIES   512
`define BPU_TAGE_ENTRIES  256
`define BPU_TAG_W         10
// upper tag bits that take part in a hit
`define BPU_PTAG_W        6

// branch target buffer
`define BPU_BTB_ENTRIES   256
`define BPU_BTB_TAG_W     14

`define BPU_RAS_DEPTH     32

// rv32 control flow opcodes
`define BPU_OP_BRANCH     7'b1100011
`define BPU_OP_JAL        7'b1101111
`define BPU_OP_JALR       7'b1100111

`endif

//--- bpu_pkg.sv
`default_nettype none
`include "bpu_consts.svh"

package bpu_pkg;

    typedef logic [`BPU_XLEN-1:0]   pc_t;
    typedef logic [`BPU_XLEN-1:0]   inst_t;
    typedef logic [`BPU_HIST_W-1:0] hist_t;
    // 2-bit saturating counter, msb is the direction
    typedef logic [1:0]             ctr_t;

    // predecoded view of one instruction word
    typedef struct packed {
        logic is_branch;
        logic is_jal;
        logic is_jalr;
        logic is_call;
        logic is_ret;
        pc_t  br_off;
        pc_t  jal_off;
    } inst_class_t;

    typedef struct packed {
        logic [`BPU_TAG_W-1:0] tag;
        ctr_t                  ctr;
    } tage_entry_t;

    typedef struct packed {
        logic [`BPU_BTB_TAG_W-1:0] tag;
        pc_t                       target;
    } btb_entry_t;

    // resolved control flow from the execute stage
    typedef struct packed {
        logic  valid;
        logic  taken;
        logic  pred_ok;
        pc_t   pc;
        hist_t history;
        pc_t   target;
        inst_t inst;
    } ex_fb_t;

    typedef struct packed {
        logic is_cf;
        logic taken;
        pc_t  target;
    } pred_t;

endpackage

`default_nettype wire

//--- bpu_predecode.sv
`timescale 1ns/1ns
`default_nettype none
`include "bpu_consts.svh"

module bpu_predecode import bpu_pkg::*; (
    input  wire inst_t   inst_i,
    output inst_class_t  class_o
);

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];

    always_comb begin
        class_o.is_branch = (opcode == `BPU_OP_BRANCH);
        class_o.is_jal    = (opcode == `BPU_OP_JAL);
        class_o.is_jalr   = (opcode == `BPU_OP_JALR);
        // any jal links, a jalr only with a real rd
        class_o.is_call   = class_o.is_jal || (class_o.is_jalr && (rd != 5'd0));
        // jalr x0, 0(ra)
        class_o.is_ret    = class_o.is_jalr && (rd == 5'd0) && (rs1 == 5'd1);

        // b-type immediate
        class_o.br_off  = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25],
                           inst_i[11:8], 1'b0};
        // j-type immediate
        class_o.jal_off = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20],
                           inst_i[30:21], 1'b0};
    end

endmodule

`default_nettype wire

//--- bpu_tagged_table.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_tagged_table #(
    parameter type      entry_t = logic,
    parameter int       ENTRIES = 256,
    localparam int      IDX_W   = $clog2(ENTRIES)
) (
    input  wire             clk,
    input  wire             rst,
    input  wire [IDX_W-1:0] rd_a_idx_i,
    output entry_t          rd_a_o,
    output logic            rd_a_valid_o,
    input  wire [IDX_W-1:0] rd_b_idx_i,
    output entry_t          rd_b_o,
    output logic            rd_b_valid_o,
    input  wire             wr_en_i,
    input  wire [IDX_W-1:0] wr_idx_i,
    input  wire entry_t     wr_data_i
);

    entry_t             mem [ENTRIES];
    logic [ENTRIES-1:0] valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_en_i) begin
            valid[wr_idx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    // port a serves fetch, port b serves training
    assign rd_a_o       = mem[rd_a_idx_i];
    assign rd_a_valid_o = valid[rd_a_idx_i];
    assign rd_b_o       = mem[rd_b_idx_i];
    assign rd_b_valid_o = valid[rd_b_idx_i];

endmodule

`default_nettype wire

//--- bpu_direction.sv
`timescale 1ns/1ns
`default_nettype none
`include "bpu_consts.svh"

module bpu_direction import bpu_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire pc_t    if_pc_i,
    input  wire ex_fb_t ex_fb_i,
    output logic        taken_o,
    output hist_t       history_o
);

    localparam int IDX_W = $clog2(`BPU_TAGE_ENTRIES);
    localparam int BIM_W = $clog2(`BPU_BIM_ENTRIES);
    localparam int TAG_W = `BPU_TAG_W;
    localparam int PAD_W = TAG_W - IDX_W;

    hist_t             history;
    ctr_t              bim [`BPU_BIM_ENTRIES];
    logic [IDX_W-1:0]  if_t0_idx, if_t1_idx, ex_t0_idx, ex_t1_idx;
    logic [TAG_W-1:0]  if_t0_tag, if_t1_tag, ex_t0_tag, ex_t1_tag;
    logic [BIM_W-1:0]  if_bim_idx, ex_bim_idx;
    tage_entry_t       if_t0, if_t1, ex_t0, ex_t1;
    logic              if_t0_vld, if_t1_vld, ex_t0_vld, ex_t1_vld;
    logic              if_t0_hit, if_t1_hit, ex_t0_hit, ex_t1_hit;
    logic              ex_t0_full, ex_t1_full;
    logic              t0_wr_en, t1_wr_en;
    tage_entry_t       t0_wr_data, t1_wr_data;

    function automatic ctr_t ctr_sat(input ctr_t c, input logic up);
        ctr_t r;
        r = c;
        if (up && (c != 2'b11)) begin
            r = c + 2'd1;
        end else if (!up && (c != 2'b00)) begin
            r = c - 2'd1;
        end
        return r;
    endfunction

    // only the upper tag bits are compared
    function automatic logic part_hit(input tage_entry_t e, input logic vld,
                                      input logic [TAG_W-1:0] tag);
        return vld && (e.tag[TAG_W-1 -: `BPU_PTAG_W] == tag[TAG_W-1 -: `BPU_PTAG_W]);
    endfunction

    // fetch side hashes
    assign if_t0_idx  = if_pc_i[IDX_W-1:0] ^ history[IDX_W-1:0];
    assign if_t1_idx  = if_pc_i[IDX_W-1:0] ^ history[`BPU_HIST_W-1 -: IDX_W];
    assign if_t0_tag  = if_pc_i[IDX_W +: TAG_W] ^ history[`BPU_HIST_W-1 -: TAG_W];
    assign if_t1_tag  = if_pc_i[IDX_W +: TAG_W] ^ {{PAD_W{1'b0}}, history[IDX_W-1:0]};
    assign if_bim_idx = if_pc_i[BIM_W:1];

    // same hashes, rebuilt from the execute snapshot
    assign ex_t0_idx  = ex_fb_i.pc[IDX_W-1:0] ^ ex_fb_i.history[IDX_W-1:0];
    assign ex_t1_idx  = ex_fb_i.pc[IDX_W-1:0] ^ ex_fb_i.history[`BPU_HIST_W-1 -: IDX_W];
    assign ex_t0_tag  = ex_fb_i.pc[IDX_W +: TAG_W] ^ ex_fb_i.history[`BPU_HIST_W-1 -: TAG_W];
    assign ex_t1_tag  = ex_fb_i.pc[IDX_W +: TAG_W]
                        ^ {{PAD_W{1'b0}}, ex_fb_i.history[IDX_W-1:0]};
    assign ex_bim_idx = ex_fb_i.pc[BIM_W:1];

    bpu_tagged_table #(.entry_t(tage_entry_t), .ENTRIES(`BPU_TAGE_ENTRIES)) i_t0 (
        .clk(clk), .rst(rst),
        .rd_a_idx_i(if_t0_idx), .rd_a_o(if_t0), .rd_a_valid_o(if_t0_vld),
        .rd_b_idx_i(ex_t0_idx), .rd_b_o(ex_t0), .rd_b_valid_o(ex_t0_vld),
        .wr_en_i(t0_wr_en), .wr_idx_i(ex_t0_idx), .wr_data_i(t0_wr_data)
    );

    bpu_tagged_table #(.entry_t(tage_entry_t), .ENTRIES(`BPU_TAGE_ENTRIES)) i_t1 (
        .clk(clk), .rst(rst),
        .rd_a_idx_i(if_t1_idx), .rd_a_o(if_t1), .rd_a_valid_o(if_t1_vld),
        .rd_b_idx_i(ex_t1_idx), .rd_b_o(ex_t1), .rd_b_valid_o(ex_t1_vld),
        .wr_en_i(t1_wr_en), .wr_idx_i(ex_t1_idx), .wr_data_i(t1_wr_data)
    );

    assign if_t0_hit  = part_hit(if_t0, if_t0_vld, if_t0_tag);
    assign if_t1_hit  = part_hit(if_t1, if_t1_vld, if_t1_tag);
    assign ex_t0_hit  = part_hit(ex_t0, ex_t0_vld, ex_t0_tag);
    assign ex_t1_hit  = part_hit(ex_t1, ex_t1_vld, ex_t1_tag);
    assign ex_t0_full = ex_t0_vld && (ex_t0.tag == ex_t0_tag);
    assign ex_t1_full = ex_t1_vld && (ex_t1.tag == ex_t1_tag);

    // provider order: t1, t0, bimodal
    assign taken_o = if_t1_hit ? if_t1.ctr[1] :
                     if_t0_hit ? if_t0.ctr[1] : bim[if_bim_idx][1];

    always_comb begin
        t1_wr_en   = 1'b0;
        t1_wr_data = ex_t1;
        t0_wr_en   = 1'b0;
        t0_wr_data = ex_t0;
        if (ex_fb_i.valid) begin
            if (ex_t1_hit) begin
                t1_wr_en       = 1'b1;
                t1_wr_data.ctr = ex_fb_i.pred_ok ? ctr_sat(ex_t1.ctr, ex_fb_i.taken)
                                                 : {2{ex_fb_i.taken}};
            end else if (ex_t0_hit) begin
                t0_wr_en       = 1'b1;
                t0_wr_data.ctr = ex_fb_i.pred_ok ? ctr_sat(ex_t0.ctr, ex_fb_i.taken)
                                                 : {2{ex_fb_i.taken}};
            end else if (!ex_fb_i.pred_ok) begin
                // bimodal missed, allocate at weak outcome
                if (!ex_t1_full) begin
                    t1_wr_en       = 1'b1;
                    t1_wr_data.tag = ex_t1_tag;
                    t1_wr_data.ctr = ex_fb_i.taken ? 2'b10 : 2'b01;
                end else if (!ex_t0_full) begin
                    t0_wr_en       = 1'b1;
                    t0_wr_data.tag = ex_t0_tag;
                    t0_wr_data.ctr = ex_fb_i.taken ? 2'b10 : 2'b01;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            history <= '0;
            for (int i = 0; i < `BPU_BIM_ENTRIES; i++) begin
                bim[i] <= 2'b01;
            end
        end else if (ex_fb_i.valid) begin
            history         <= {history[`BPU_HIST_W-2:0], ex_fb_i.taken};
            bim[ex_bim_idx] <= ctr_sat(bim[ex_bim_idx], ex_fb_i.taken);
        end
    end

    assign history_o = history;

endmodule

`default_nettype wire

//--- bpu_ras.sv
`timescale 1ns/1ns
`default_nettype none
`include "bpu_consts.svh"

module bpu_ras import bpu_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire              flush_i,
    input  wire              ex_valid_i,
    input  wire              ex_taken_i,
    input  wire pc_t         ex_pc_i,
    input  wire inst_class_t ex_class_i,
    output logic             top_valid_o,
    output pc_t              top_o
);

    localparam int             PTR_W      = $clog2(`BPU_RAS_DEPTH);
    localparam logic [PTR_W:0] FULL_DEPTH = `BPU_RAS_DEPTH;

    pc_t              stack [`BPU_RAS_DEPTH];
    logic [PTR_W:0]   depth;
    logic             upd, push, pop, full;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] top_ptr;

    // a flushed strobe belongs to a squashed path
    assign upd  = ex_valid_i && !flush_i;
    assign push = upd && ex_class_i.is_call && ex_taken_i;
    assign pop  = upd && ex_class_i.is_ret && (depth != '0);
    assign full = (depth == FULL_DEPTH);

    // on overflow restart from the bottom entry
    assign wr_ptr  = full ? '0 : depth[PTR_W-1:0];
    assign top_ptr = depth[PTR_W-1:0] - 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            depth <= '0;
        end else if (push) begin
            depth <= full ? (PTR_W+1)'(1) : depth + 1'b1;
        end else if (pop) begin
            depth <= depth - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stack[wr_ptr] <= ex_pc_i + pc_t'(4);
        end
    end

    assign top_valid_o = (depth != '0);
    assign top_o       = stack[top_ptr];

endmodule

`default_nettype wire

//--- bpu_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "bpu_consts.svh"

module bpu_top import bpu_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         flush_i,
    input  wire pc_t    if_pc_i,
    input  wire inst_t  if_inst_i,
    input  wire ex_fb_t ex_fb_i,
    output pred_t       pred_o,
    output hist_t       history_o
);

    localparam int BTB_IDX_W = $clog2(`BPU_BTB_ENTRIES);

    inst_class_t                if_class, ex_class;
    logic                       dir_taken;
    logic                       ras_valid;
    pc_t                        ras_top;
    logic [BTB_IDX_W-1:0]       if_btb_idx, ex_btb_idx;
    logic [`BPU_BTB_TAG_W-1:0]  if_btb_tag, ex_btb_tag;
    btb_entry_t                 if_btb, ex_btb, btb_wr_data;
    logic                       if_btb_vld, ex_btb_vld;
    logic                       btb_hit, btb_same, btb_wr_en;

    bpu_predecode i_pd_if (.inst_i(if_inst_i), .class_o(if_class));
    bpu_predecode i_pd_ex (.inst_i(ex_fb_i.inst), .class_o(ex_class));

    bpu_direction i_dir (
        .clk(clk), .rst(rst), .if_pc_i(if_pc_i), .ex_fb_i(ex_fb_i),
        .taken_o(dir_taken), .history_o(history_o)
    );

    bpu_ras i_ras (
        .clk(clk), .rst(rst), .flush_i(flush_i),
        .ex_valid_i(ex_fb_i.valid), .ex_taken_i(ex_fb_i.taken),
        .ex_pc_i(ex_fb_i.pc), .ex_class_i(ex_class),
        .top_valid_o(ras_valid), .top_o(ras_top)
    );

    // btb uses word index and the top pc bits as tag
    assign if_btb_idx = if_pc_i[BTB_IDX_W+1:2];
    assign if_btb_tag = if_pc_i[`BPU_XLEN-1 -: `BPU_BTB_TAG_W];
    assign ex_btb_idx = ex_fb_i.pc[BTB_IDX_W+1:2];
    assign ex_btb_tag = ex_fb_i.pc[`BPU_XLEN-1 -: `BPU_BTB_TAG_W];

    bpu_tagged_table #(.entry_t(btb_entry_t), .ENTRIES(`BPU_BTB_ENTRIES)) i_btb (
        .clk(clk), .rst(rst),
        .rd_a_idx_i(if_btb_idx), .rd_a_o(if_btb), .rd_a_valid_o(if_btb_vld),
        .rd_b_idx_i(ex_btb_idx), .rd_b_o(ex_btb), .rd_b_valid_o(ex_btb_vld),
        .wr_en_i(btb_wr_en), .wr_idx_i(ex_btb_idx), .wr_data_i(btb_wr_data)
    );

    assign btb_hit     = if_btb_vld && (if_btb.tag == if_btb_tag);
    // skip the write when the slot already holds this target
    assign btb_same    = ex_btb_vld && (ex_btb.tag == ex_btb_tag)
                         && (ex_btb.target == ex_fb_i.target);
    assign btb_wr_en   = ex_fb_i.valid && ex_fb_i.taken && !btb_same
                         && (ex_class.is_branch || ex_class.is_jal || ex_class.is_jalr);
    assign btb_wr_data = '{tag: ex_btb_tag, target: ex_fb_i.target};

    always_comb begin
        pred_o.is_cf  = if_class.is_branch || if_class.is_jal || if_class.is_jalr;
        pred_o.taken  = 1'b0;
        pred_o.target = if_pc_i + pc_t'(4);
        if (if_class.is_ret) begin
            // ras first, btb as fallback
            if (ras_valid) begin
                pred_o.taken  = 1'b1;
                pred_o.target = ras_top;
            end else if (btb_hit) begin
                pred_o.taken  = 1'b1;
                pred_o.target = if_btb.target;
            end
        end else if (if_class.is_jalr) begin
            if (btb_hit) begin
                pred_o.taken  = 1'b1;
                pred_o.target = if_btb.target;
            end
        end else if (if_class.is_jal || if_class.is_branch) begin
            pred_o.taken = if_class.is_jal || dir_taken;
            if (pred_o.taken) begin
                pred_o.target = btb_hit ? if_btb.target :
                                if_pc_i + (if_class.is_jal ? if_class.jal_off
                                                           : if_class.br_off);
            end
        end
    end

endmodule

`default_nettype wire

//--- bpu_tb_clk.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_tb_clk #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- bpu_chk.sv
`timescale 1ns/1ns
`default_nettype none
`include "bpu_consts.svh"

module bpu_chk import bpu_pkg::*; (
    input wire         clk,
    input wire         rst,
    input wire pc_t    if_pc_i,
    input wire inst_t  if_inst_i,
    input wire ex_fb_t ex_fb_i,
    input wire pred_t  pred_i,
    input wire hist_t  history_i
);

    int unsigned fail_cnt = 0;
    logic [6:0]  opcode;
    logic        cf_op;

    assign opcode = if_inst_i[6:0];
    assign cf_op  = (opcode == `BPU_OP_BRANCH) || (opcode == `BPU_OP_JAL)
                    || (opcode == `BPU_OP_JALR);

    // plain instructions fall through to the next word
    a_noncf: assert property (@(posedge clk) disable iff (rst)
        !cf_op |-> (!pred_i.is_cf && !pred_i.taken && (pred_i.target == if_pc_i + 32'd4)))
    else begin
        $error("non control flow word predicted as control flow");
        fail_cnt++;
    end

    a_jal_taken: assert property (@(posedge clk) disable iff (rst)
        (opcode == `BPU_OP_JAL) |-> (pred_i.is_cf && pred_i.taken))
    else begin
        $error("jal not predicted taken");
        fail_cnt++;
    end

    a_hist_reset: assert property (@(posedge clk)
        rst |=> (history_i == '0))
    else begin
        $error("history not cleared by reset");
        fail_cnt++;
    end

    // each strobe shifts in its outcome
    a_hist_shift: assert property (@(posedge clk) disable iff (rst)
        ex_fb_i.valid |=> (history_i == {$past(history_i[`BPU_HIST_W-2:0]),
                                         $past(ex_fb_i.taken)}))
    else begin
        $error("history did not shift in the outcome");
        fail_cnt++;
    end

    a_hist_hold: assert property (@(posedge clk) disable iff (rst)
        !ex_fb_i.valid |=> $stable(history_i))
    else begin
        $error("history changed without a strobe");
        fail_cnt++;
    end

endmodule

`default_nettype wire

//--- bpu_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "bpu_consts.svh"

module bpu_tb import bpu_pkg::*; ();

    localparam int          CLK_NS     = 20;
    localparam int          RST_CYCLES = 10;
    localparam int          N_NONCF    = 24;
    localparam int          N_JAL      = 16;
    localparam int          N_PROBES   = N_NONCF + N_JAL + 16;
    localparam int          N_STROBES  = 64;
    // a probe takes one cycle and a strobe two
    localparam int          RUN_CYCLES = RST_CYCLES + N_PROBES + 2 * N_STROBES + 50;
    localparam logic [31:0] SEED       = 32'ha3d5;
    localparam inst_t       RET_INST   = 32'h0000_8067;
    localparam pc_t         RET_PC     = 32'h0008_0300;
    localparam pc_t         RET2_PC    = 32'h00c0_0340;
    localparam pc_t         BR_PC      = 32'h0004_0100;
    localparam pc_t         BR_TGT     = 32'h0004_0800;
    localparam pc_t         Q_PC       = 32'h0002_0a00;
    localparam pc_t         Q_TGT      = 32'h0002_0f00;
    localparam hist_t       Q_HIST     = 16'h5a3c;
    localparam pc_t         FILL_PC    = 32'h0003_0010;

    logic        clk, rst, flush;
    pc_t         if_pc;
    inst_t       if_inst;
    ex_fb_t      ex_fb;
    pred_t       pred;
    hist_t       history;
    hist_t       hist_m;
    pc_t         ras_q[$];
    int unsigned err_cnt;
    int unsigned chk_fails;

    bpu_tb_clk #(.PERIOD_NS(CLK_NS), .RST_CYCLES(RST_CYCLES)) i_clk (
        .clk_o(clk), .rst_o(rst)
    );

    bpu_top i_dut (
        .clk(clk), .rst(rst), .flush_i(flush), .if_pc_i(if_pc), .if_inst_i(if_inst),
        .ex_fb_i(ex_fb), .pred_o(pred), .history_o(history)
    );

    bind bpu_top bpu_chk i_chk (
        .clk(clk), .rst(rst), .if_pc_i(if_pc_i), .if_inst_i(if_inst_i),
        .ex_fb_i(ex_fb_i), .pred_i(pred_o), .history_i(history_o)
    );

    function automatic inst_t enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `BPU_OP_JAL};
    endfunction

    // beq x0, x0
    function automatic inst_t enc_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], `BPU_OP_BRANCH};
    endfunction

    task automatic probe(input pc_t pc, input inst_t inst, input logic exp_cf,
                         input logic exp_taken, input pc_t exp_target);
        @(posedge clk);
        if_pc   <= pc;
        if_inst <= inst;
        @(negedge clk);
        if (pred.is_cf !== exp_cf || pred.taken !== exp_taken
            || pred.target !== exp_target) begin
            $display("Mismatch at %0t: pc %h inst %h cf %b taken %b tgt %h, expected %b %b %h",
                     $time, pc, inst, pred.is_cf, pred.taken, pred.target,
                     exp_cf, exp_taken, exp_target);
            err_cnt++;
        end
    endtask

    task automatic strobe(input pc_t pc, input inst_t inst, input logic taken,
                          input logic pred_ok, input pc_t target, input hist_t hist,
                          input logic flushed);
        @(posedge clk);
        ex_fb <= '{valid: 1'b1, taken: taken, pred_ok: pred_ok, pc: pc, history: hist,
                   target: target, inst: inst};
        flush <= flushed;
        @(posedge clk);
        ex_fb.valid <= 1'b0;
        flush       <= 1'b0;
        hist_m = {hist_m[`BPU_HIST_W-2:0], taken};
        @(negedge clk);
        if (history !== hist_m) begin
            $display("Mismatch at %0t: history %h, expected %h", $time, history, hist_m);
            err_cnt++;
        end
    endtask

    // taken jal with rd = ra
    task automatic call(input pc_t pc, input logic flushed);
        strobe(pc, enc_jal(5'd1, 21'h100), 1'b1, 1'b1, pc + 32'h100, hist_m, flushed);
        if (!flushed) begin
            if (ras_q.size() == `BPU_RAS_DEPTH) begin
                ras_q.delete();
            end
            ras_q.push_back(pc + 32'd4);
        end
    endtask

    task automatic return_pop();
        pc_t top;
        top = ras_q[$];
        probe(RET_PC, RET_INST, 1'b1, 1'b1, top);
        strobe(RET_PC, RET_INST, 1'b1, 1'b1, top, hist_m, 1'b0);
        void'(ras_q.pop_back());
    endtask

    initial begin
        pc_t         pc;
        inst_t       inst;
        logic [20:0] off;
        void'($urandom(SEED));
        err_cnt = 0;
        hist_m  = '0;
        flush   = 1'b0;
        if_pc   = '0;
        if_inst = 32'h0000_0013;
        ex_fb   = '0;
        @(negedge rst);
        @(negedge clk);
        if (history !== '0) begin
            $display("Mismatch at %0t: history %h after reset", $time, history);
            err_cnt++;
        end

        repeat (N_NONCF) begin
            pc   = $urandom & 32'hffff_fffc;
            inst = $urandom;
            if (inst[6:0] == `BPU_OP_BRANCH || inst[6:0] == `BPU_OP_JAL
                || inst[6:0] == `BPU_OP_JALR) begin
                inst[6:0] = 7'b0110011;
            end
            probe(pc, inst, 1'b0, 1'b0, pc + 32'd4);
        end

        // btb still empty so the target comes from the offset
        repeat (N_JAL) begin
            pc  = $urandom & 32'hffff_fffc;
            off = $urandom & 21'h1f_fffe;
            probe(pc, enc_jal(5'd0, off), 1'b1, 1'b1, pc + {{11{off[20]}}, off});
        end

        probe(BR_PC, enc_branch(13'h040), 1'b1, 1'b0, BR_PC + 32'd4);
        repeat (2) begin
            strobe(BR_PC, enc_branch(13'h040), 1'b1, 1'b1, BR_TGT, hist_m, 1'b0);
        end
        probe(BR_PC, enc_branch(13'h040), 1'b1, 1'b1, BR_TGT);

        for (int i = 0; i < 3; i++) begin
            call(32'h0010_0000 + 32'(i) * 32'h40, 1'b0);
        end
        call(32'h0010_0400, 1'b1);
        while (ras_q.size() != 0) begin
            return_pop();
        end
        for (int i = 0; i < 33; i++) begin
            call(32'h0100_0000 + 32'(i) * 32'd4, 1'b0);
        end
        return_pop();
        probe(RET2_PC, RET_INST, 1'b1, 1'b0, RET2_PC + 32'd4);

        // bimodal miss allocates a weak taken t1 entry
        strobe(Q_PC, enc_branch(13'h080), 1'b1, 1'b0, Q_TGT, Q_HIST, 1'b0);
        strobe(Q_PC, enc_branch(13'h080), 1'b0, 1'b1, Q_PC + 32'd4, '0, 1'b0);
        // rebuild Q_HIST one bit at a time
        for (int i = `BPU_HIST_W - 1; i >= 0; i--) begin
            strobe(FILL_PC, enc_branch(13'h040), Q_HIST[i], 1'b1, FILL_PC + 32'h40, '0, 1'b0);
        end
        probe(Q_PC, enc_branch(13'h080), 1'b1, 1'b1, Q_TGT);

        repeat (2) @(posedge clk);
        chk_fails = i_dut.i_chk.fail_cnt;
        $display("errors: %0d mismatches, %0d assertion failures", err_cnt, chk_fails);
        if (err_cnt == 0 && chk_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_NS);
        $display("Timeout: run did not finish within %0d ns", RUN_CYCLES * CLK_NS);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
bpu_pkg.sv
bpu_predecode.sv
bpu_tagged_table.sv
bpu_direction.sv
bpu_ras.sv
bpu_top.sv
bpu_tb_clk.sv
bpu_chk.sv
bpu_tb.sv

//--- Bender.yml
package:
  name: bpu

sources:
  - include_dirs:
      - .
    files:
      - bpu_pkg.sv
      - bpu_predecode.sv
      - bpu_tagged_table.sv
      - bpu_direction.sv
      - bpu_ras.sv
      - bpu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - bpu_tb_clk.sv
      - bpu_chk.sv
      - bpu_tb.sv
